/* include/mem_cfg.svh */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// address and register data width
`define MEM_XLEN 32

// AXI data bus, two 32-bit lanes
`define MEM_BUS_W 64
`define MEM_STRB_W 8

// bytes in one 32-bit lane
`define MEM_LANE_BYTES 4

`endif

/* rtl/mem_pkg.sv */
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

	// load/store operation code
	typedef enum logic [3:0] {
		op_none = 4'd0,
		op_lw   = 4'd1,
		op_lh   = 4'd2,
		op_lhu  = 4'd3,
		op_lb   = 4'd4,
		op_lbu  = 4'd5,
		op_sw   = 4'd6,
		op_sh   = 4'd7,
		op_sb   = 4'd8
	} mem_op_e;

	// byte address, either raw or split into bus fields
	typedef union packed {
		logic [`MEM_XLEN-1:0] raw;
		struct packed {
			logic [`MEM_XLEN-4:0] word;
			logic                 lane;
			logic [1:0]           offset;
		} f;
	} addr_u;

endpackage

`default_nettype wire

/* rtl/mem_issue.sv */
`default_nettype none

`include "mem_cfg.svh"

module mem_issue (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 in_valid,
	input  wire mem_pkg::mem_op_e     in_op,
	input  wire logic [`MEM_XLEN-1:0] in_addr,
	input  wire logic [`MEM_XLEN-1:0] in_wdata,
	output logic                      in_ready,
	output mem_pkg::mem_op_e          op,
	output logic [`MEM_XLEN-1:0]      addr,
	output logic [`MEM_XLEN-1:0]      wdata,
	output logic                      second,
	output logic                      read_start,
	output logic                      write_start,
	input  wire logic                 need_second,
	input  wire logic                 read_beat_done,
	input  wire logic                 write_beat_done,
	output logic                      done
);

	logic busy;
	logic launch;
	logic accept;
	logic beat_done;
	logic is_load;
	logic is_store;
	logic more_beats;

	assign accept = in_valid && in_ready;
	assign beat_done = read_beat_done || write_beat_done;
	assign more_beats = beat_done && need_second && !second;

	// final beat finished, stage can take the next request
	assign done = beat_done && (!need_second || second);
	assign in_ready = !busy || done;

	assign is_load = op inside {mem_pkg::op_lw, mem_pkg::op_lh, mem_pkg::op_lhu,
		mem_pkg::op_lb, mem_pkg::op_lbu};
	assign is_store = op inside {mem_pkg::op_sw, mem_pkg::op_sh, mem_pkg::op_sb};

	assign read_start = launch && is_load;
	assign write_start = launch && is_store;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			launch <= 1'b0;
			second <= 1'b0;
		end else begin
			if (in_ready)
				busy <= in_valid;
			// one start pulse per beat
			launch <= accept || more_beats;
			if (accept)
				second <= 1'b0;
			else if (more_beats)
				second <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op <= in_op;
			addr <= in_addr;
			wdata <= in_wdata;
		end
	end

endmodule

`default_nettype wire

/* rtl/access_split.sv */
`default_nettype none

`include "mem_cfg.svh"

module access_split (
	input  wire mem_pkg::mem_op_e           op,
	input  wire logic [`MEM_XLEN-1:0]       addr,
	input  wire logic [`MEM_XLEN-1:0]       wdata,
	input  wire logic                       second,
	output logic                            need_second,
	output logic [`MEM_XLEN-1:0]            beat_addr,
	output logic [`MEM_STRB_W-1:0]          beat_strb,
	output logic [`MEM_BUS_W-1:0]           beat_wdata,
	output logic [`MEM_LANE_BYTES-1:0]      first_strb,
	output logic [`MEM_LANE_BYTES-1:0]      second_strb
);

	mem_pkg::addr_u                  a;
	logic [`MEM_LANE_BYTES-1:0]      size_mask;
	logic [2*`MEM_LANE_BYTES-1:0]    span;
	logic [`MEM_XLEN-1:0]            base;
	logic [5:0]                      lo_shift;
	logic [5:0]                      hi_shift;
	logic [`MEM_XLEN-1:0]            lane_data;

	assign a.raw = addr;

	// bytes touched by the access, before shifting to the offset
	always_comb begin
		case (op)
			mem_pkg::op_lw, mem_pkg::op_sw:
				size_mask = 4'b1111;
			mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh:
				size_mask = 4'b0011;
			mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb:
				size_mask = 4'b0001;
			default:
				size_mask = 4'b0000;
		endcase
	end

	// upper half of span holds the bytes that spill into the next word
	assign span = {4'b0000, size_mask} << a.f.offset;
	assign first_strb = span[`MEM_LANE_BYTES-1:0];
	assign second_strb = span[2*`MEM_LANE_BYTES-1:`MEM_LANE_BYTES];
	assign need_second = |second_strb;

	assign base = {a.f.word, a.f.lane, 2'b00};
	assign beat_addr = second ? base + `MEM_XLEN'(`MEM_LANE_BYTES) : base;

	// byte offset in bits, and what is left for the second beat
	assign lo_shift = {1'b0, a.f.offset, 3'b000};
	assign hi_shift = 6'd32 - lo_shift;
	assign lane_data = second ? (wdata >> hi_shift) : (wdata << lo_shift);

	// slave picks its lane by address bit 2, so drive both halves
	assign beat_strb = {2{second ? second_strb : first_strb}};
	assign beat_wdata = {2{lane_data}};

endmodule

`default_nettype wire

/* rtl/axi_read_fsm.sv */
`default_nettype none

`include "mem_cfg.svh"

module axi_read_fsm (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  start,
	input  wire logic [`MEM_XLEN-1:0]  beat_addr,
	input  wire logic                  need_second,
	input  wire logic                  second,
	output logic                       arvalid,
	output logic [`MEM_XLEN-1:0]       araddr,
	output logic                       rready,
	input  wire logic                  arready,
	input  wire logic                  rvalid,
	input  wire logic [`MEM_BUS_W-1:0] rdata,
	output logic [`MEM_XLEN-1:0]       first_rdata,
	output logic [`MEM_XLEN-1:0]       last_rdata,
	output logic                       beat_done
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_done = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (start) state_next = st_addr;
			st_addr: if (arready) state_next = st_data;
			st_data: if (rvalid) state_next = st_done;
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	assign arvalid = (state == st_addr);
	assign rready = (state == st_data);
	assign beat_done = (state == st_done);

	// address held constant for the whole beat
	always_ff @(posedge clock) begin
		if (state == st_idle && start)
			araddr <= beat_addr;
	end

	// slave returns the addressed lane in the low half
	always_ff @(posedge clock) begin
		if (rvalid && rready) begin
			last_rdata <= rdata[`MEM_XLEN-1:0];
			if (need_second && !second)
				first_rdata <= rdata[`MEM_XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

/* rtl/axi_write_fsm.sv */
`default_nettype none

`include "mem_cfg.svh"

module axi_write_fsm (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   start,
	input  wire logic [`MEM_XLEN-1:0]   beat_addr,
	input  wire logic [`MEM_STRB_W-1:0] beat_strb,
	input  wire logic [`MEM_BUS_W-1:0]  beat_wdata,
	output logic                        awvalid,
	output logic [`MEM_XLEN-1:0]        awaddr,
	output logic                        wvalid,
	output logic [`MEM_BUS_W-1:0]       wdata,
	output logic [`MEM_STRB_W-1:0]      wstrb,
	output logic                        wlast,
	output logic                        bready,
	input  wire logic                   awready,
	input  wire logic                   wready,
	input  wire logic                   bvalid,
	output logic                        beat_done
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_resp = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;

	// address phase, then data, then response
	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (start) state_next = st_addr;
			st_addr: if (awready) state_next = st_data;
			st_data: if (wready) state_next = st_resp;
			default: if (bvalid) state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	assign awvalid = (state == st_addr);
	assign wvalid = (state == st_data);
	// single-beat transfers, every data beat is the last
	assign wlast = wvalid;
	assign bready = (state == st_resp);
	assign beat_done = bready && bvalid;

	always_ff @(posedge clock) begin
		if (state == st_idle && start) begin
			awaddr <= beat_addr;
			wdata <= beat_wdata;
			wstrb <= beat_strb;
		end
	end

endmodule

`default_nettype wire

/* rtl/load_align.sv */
`default_nettype none

`include "mem_cfg.svh"

module load_align (
	input  wire mem_pkg::mem_op_e           op,
	input  wire logic [`MEM_XLEN-1:0]       addr,
	input  wire logic                       need_second,
	input  wire logic [`MEM_XLEN-1:0]       first_rdata,
	input  wire logic [`MEM_XLEN-1:0]       last_rdata,
	input  wire logic [`MEM_LANE_BYTES-1:0] first_strb,
	input  wire logic [`MEM_LANE_BYTES-1:0] second_strb,
	output logic [`MEM_XLEN-1:0]            load_data
);

	mem_pkg::addr_u          a;
	logic [`MEM_XLEN-1:0]    first_word;
	logic [`MEM_XLEN-1:0]    gathered;
	logic [2*`MEM_XLEN-1:0]  doubled;
	logic [`MEM_XLEN-1:0]    rot;

	assign a.raw = addr;

	// unsplit load has only the final beat
	assign first_word = need_second ? first_rdata : last_rdata;

	always_comb begin
		gathered = '0;
		for (int i = 0; i < `MEM_LANE_BYTES; i++) begin
			if (first_strb[i])
				gathered[8*i +: 8] = first_word[8*i +: 8];
			else if (second_strb[i])
				gathered[8*i +: 8] = last_rdata[8*i +: 8];
		end
	end

	// rotate right by the offset so the first access byte lands in byte 0
	assign doubled = {gathered, gathered} >> {a.f.offset, 3'b000};
	assign rot = doubled[`MEM_XLEN-1:0];

	always_comb begin
		case (op)
			mem_pkg::op_lw:  load_data = rot;
			mem_pkg::op_lh:  load_data = {{16{rot[15]}}, rot[15:0]};
			mem_pkg::op_lhu: load_data = {16'h0000, rot[15:0]};
			mem_pkg::op_lb:  load_data = {{24{rot[7]}}, rot[7:0]};
			mem_pkg::op_lbu: load_data = {24'h000000, rot[7:0]};
			default:         load_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`default_nettype none

`include "mem_cfg.svh"

module mem_stage (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   in_valid,
	input  wire mem_pkg::mem_op_e       in_op,
	input  wire logic [`MEM_XLEN-1:0]   in_addr,
	input  wire logic [`MEM_XLEN-1:0]   in_wdata,
	output logic                        in_ready,
	output logic                        done,
	output logic [`MEM_XLEN-1:0]        load_data,
	output logic                        arvalid,
	output logic [`MEM_XLEN-1:0]        araddr,
	input  wire logic                   arready,
	input  wire logic                   rvalid,
	output logic                        rready,
	input  wire logic [`MEM_BUS_W-1:0]  rdata,
	output logic                        awvalid,
	output logic [`MEM_XLEN-1:0]        awaddr,
	input  wire logic                   awready,
	output logic                        wvalid,
	output logic [`MEM_BUS_W-1:0]       wdata,
	output logic [`MEM_STRB_W-1:0]      wstrb,
	output logic                        wlast,
	input  wire logic                   wready,
	input  wire logic                   bvalid,
	output logic                        bready
);

	mem_pkg::mem_op_e               req_op;
	logic [`MEM_XLEN-1:0]           req_addr;
	logic [`MEM_XLEN-1:0]           req_wdata;
	logic                           second;
	logic                           need_second;
	logic                           read_start;
	logic                           write_start;
	logic                           read_beat_done;
	logic                           write_beat_done;
	logic [`MEM_XLEN-1:0]           beat_addr;
	logic [`MEM_STRB_W-1:0]         beat_strb;
	logic [`MEM_BUS_W-1:0]          beat_wdata;
	logic [`MEM_LANE_BYTES-1:0]     first_strb;
	logic [`MEM_LANE_BYTES-1:0]     second_strb;
	logic [`MEM_XLEN-1:0]           first_rdata;
	logic [`MEM_XLEN-1:0]           last_rdata;

	mem_issue u_issue (
		.clock(clock), .reset(reset),
		.in_valid(in_valid), .in_op(in_op), .in_addr(in_addr), .in_wdata(in_wdata),
		.in_ready(in_ready), .op(req_op), .addr(req_addr), .wdata(req_wdata),
		.second(second), .read_start(read_start), .write_start(write_start),
		.need_second(need_second), .read_beat_done(read_beat_done),
		.write_beat_done(write_beat_done), .done(done)
	);

	access_split u_split (
		.op(req_op), .addr(req_addr), .wdata(req_wdata), .second(second),
		.need_second(need_second), .beat_addr(beat_addr), .beat_strb(beat_strb),
		.beat_wdata(beat_wdata), .first_strb(first_strb), .second_strb(second_strb)
	);

	axi_read_fsm u_read (
		.clock(clock), .reset(reset), .start(read_start), .beat_addr(beat_addr),
		.need_second(need_second), .second(second),
		.arvalid(arvalid), .araddr(araddr), .rready(rready),
		.arready(arready), .rvalid(rvalid), .rdata(rdata),
		.first_rdata(first_rdata), .last_rdata(last_rdata), .beat_done(read_beat_done)
	);

	axi_write_fsm u_write (
		.clock(clock), .reset(reset), .start(write_start),
		.beat_addr(beat_addr), .beat_strb(beat_strb), .beat_wdata(beat_wdata),
		.awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
		.wstrb(wstrb), .wlast(wlast), .bready(bready),
		.awready(awready), .wready(wready), .bvalid(bvalid),
		.beat_done(write_beat_done)
	);

	load_align u_align (
		.op(req_op), .addr(req_addr), .need_second(need_second),
		.first_rdata(first_rdata), .last_rdata(last_rdata),
		.first_strb(first_strb), .second_strb(second_strb), .load_data(load_data)
	);

endmodule

`default_nettype wire

/* tests/mem_stage_properties.sv */
`default_nettype none

`include "mem_cfg.svh"

module mem_stage_properties (
	input wire logic                   clock,
	input wire logic                   reset,
	input wire logic                   in_valid,
	input wire logic                   in_ready,
	input wire logic                   done,
	input wire logic                   arvalid,
	input wire logic                   arready,
	input wire logic [`MEM_XLEN-1:0]   araddr,
	input wire logic                   awvalid,
	input wire logic                   awready,
	input wire logic [`MEM_XLEN-1:0]   awaddr,
	input wire logic                   wvalid,
	input wire logic                   wready,
	input wire logic [`MEM_BUS_W-1:0]  wdata,
	input wire logic [`MEM_STRB_W-1:0] wstrb
);

	timeunit 1ns;
	timeprecision 1ps;

	logic pending;
	// assertion failures so far, the testbench folds them into its verdict
	int failures = 0;

	// open from acceptance until the matching done
	always_ff @(posedge clock) begin
		if (reset)
			pending <= 1'b0;
		else if (in_valid && in_ready)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			failures++;
			$error("arvalid dropped or araddr changed before arready");
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			failures++;
			$error("awvalid dropped or awaddr changed before awready");
		end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			failures++;
			$error("wvalid dropped or write data changed before wready");
		end

	done_after_accept: assert property (@(posedge clock) disable iff (reset)
		done |-> pending)
		else begin
			failures++;
			$error("done without an accepted request");
		end

	one_channel: assert property (@(posedge clock) disable iff (reset)
		!(arvalid && awvalid))
		else begin
			failures++;
			$error("arvalid and awvalid high together");
		end

endmodule

bind mem_stage mem_stage_properties u_properties (.*);

`default_nettype wire

/* tests/mem_stage_tb.sv */
`default_nettype none

`include "mem_cfg.svh"

module mem_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic                     clock;
	logic                     reset;
	logic                     in_valid;
	mem_pkg::mem_op_e         in_op;
	logic [`MEM_XLEN-1:0]     in_addr;
	logic [`MEM_XLEN-1:0]     in_wdata;
	logic                     in_ready;
	logic                     done;
	logic [`MEM_XLEN-1:0]     load_data;
	logic                     arvalid;
	logic [`MEM_XLEN-1:0]     araddr;
	logic                     arready;
	logic                     rvalid;
	logic                     rready;
	logic [`MEM_BUS_W-1:0]    rdata;
	logic                     awvalid;
	logic [`MEM_XLEN-1:0]     awaddr;
	logic                     awready;
	logic                     wvalid;
	logic [`MEM_BUS_W-1:0]    wdata;
	logic [`MEM_STRB_W-1:0]   wstrb;
	logic                     wlast;
	logic                     wready;
	logic                     bvalid;
	logic                     bready;

	logic [3:0]               vec_op[$];
	logic [31:0]              vec_addr[$];
	logic [31:0]              vec_wdata[$];
	logic [31:0]              vec_expect[$];
	// slave memory and the expected byte image
	logic [7:0]               mem_bytes[0:63];
	logic [7:0]               ref_bytes[0:63];
	logic [31:0]              addr_log[$];
	int                       checks = 0;
	int                       errors = 0;
	int                       accepts = 0;
	int                       done_count = 0;
	int                       cycles = 0;
	int                       cycle_limit = 100;

	mem_stage DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (done)
			done_count++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped finishing accesses", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic int op_bytes(input logic [3:0] op);
		case (op)
			mem_pkg::op_lw, mem_pkg::op_sw: return 4;
			mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: return 2;
			default: return 1;
		endcase
	endfunction

	// load result straight from the byte image, little endian
	function automatic logic [31:0] ref_load(input logic [3:0] op, input logic [31:0] addr);
		logic [31:0] v;
		int a;
		a = int'(addr[5:0]);
		v = {ref_bytes[(a + 3) % 64], ref_bytes[(a + 2) % 64],
			ref_bytes[(a + 1) % 64], ref_bytes[a]};
		case (op)
			mem_pkg::op_lh:  return {{16{v[15]}}, v[15:0]};
			mem_pkg::op_lhu: return {16'h0000, v[15:0]};
			mem_pkg::op_lb:  return {{24{v[7]}}, v[7:0]};
			mem_pkg::op_lbu: return {24'h000000, v[7:0]};
			default:         return v;
		endcase
	endfunction

	function automatic int load_vectors();
		int fd;
		string line;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] w;
		logic [31:0] e;
		fd = $fopen("tests/mem_vectors.txt", "r");
		if (fd == 0)
			return -1;
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line[0] != "#" &&
				$sscanf(line, "%h %h %h %h", op, a, w, e) == 4) begin
				vec_op.push_back(op[3:0]);
				vec_addr.push_back(a);
				vec_wdata.push_back(w);
				vec_expect.push_back(e);
			end
		end
		$fclose(fd);
		return vec_op.size();
	endfunction

	task automatic run_vector(input int n);
		string name;
		logic [3:0] op;
		logic [31:0] addr;
		logic [31:0] wd;
		logic [31:0] base;
		logic [31:0] got;
		int size;
		bit split;
		name = $sformatf("vector %0d", n + 1);
		op = vec_op[n];
		addr = vec_addr[n];
		wd = vec_wdata[n];
		size = op_bytes(op);
		base = addr & ~32'h3;
		split = (int'(addr[1:0]) + size) > 4;
		addr_log.delete();
		@(negedge clock);
		in_valid = 1'b1;
		in_op = mem_pkg::mem_op_e'(op);
		in_addr = addr;
		in_wdata = wd;
		@(posedge clock);
		while (!in_ready)
			@(posedge clock);
		accepts++;
		@(negedge clock);
		in_valid = 1'b0;
		// load data only holds in the cycle of done
		@(posedge clock);
		while (!done)
			@(posedge clock);
		got = load_data;
		check_value({name, " beats"}, split ? 2 : 1, addr_log.size());
		if (addr_log.size() > 0)
			check_value({name, " first address"}, base, addr_log[0]);
		if (split && addr_log.size() > 1)
			check_value({name, " second address"}, base + 4, addr_log[1]);
		if (op >= mem_pkg::op_sw) begin
			for (int k = 0; k < size; k++)
				ref_bytes[(int'(addr[5:0]) + k) % 64] = wd[8*k +: 8];
			for (int i = 0; i < 64; i++)
				check_value($sformatf("%s byte %0d", name, i), ref_bytes[i], mem_bytes[i]);
		end else begin
			check_value(name, vec_expect[n], got);
			check_value({name, " byte image"}, ref_load(op, addr), got);
		end
	endtask

	// AXI slave over mem_bytes, 0 to 3 wait states per phase
	initial begin
		logic [31:0] a;
		int b;
		int lane;
		void'($urandom(32'h8682_4f74));
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		forever begin
			@(negedge clock);
			if (arvalid) begin
				repeat ($urandom % 4)
					@(negedge clock);
				a = araddr;
				arready = 1'b1;
				@(negedge clock);
				arready = 1'b0;
				addr_log.push_back(a);
				b = int'(a[5:2]) * 4;
				repeat ($urandom % 4)
					@(negedge clock);
				rdata[31:0] = {mem_bytes[b + 3], mem_bytes[b + 2], mem_bytes[b + 1], mem_bytes[b]};
				rdata[63:32] = ~rdata[31:0];
				rvalid = 1'b1;
				@(negedge clock);
				rvalid = 1'b0;
			end else if (awvalid) begin
				repeat ($urandom % 4)
					@(negedge clock);
				a = awaddr;
				awready = 1'b1;
				@(negedge clock);
				awready = 1'b0;
				addr_log.push_back(a);
				b = int'(a[5:2]) * 4;
				lane = int'(a[2]);
				repeat ($urandom % 4)
					@(negedge clock);
				wready = 1'b1;
				check_value("wlast", 1, wlast);
				// lane picked by address bit 2
				for (int k = 0; k < 4; k++)
					if (wstrb[4*lane + k])
						mem_bytes[b + k] = wdata[32*lane + 8*k +: 8];
				@(negedge clock);
				wready = 1'b0;
				repeat ($urandom % 4)
					@(negedge clock);
				bvalid = 1'b1;
				@(negedge clock);
				bvalid = 1'b0;
			end
		end
	end

	initial begin
		int count;
		int assert_fails;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = mem_pkg::op_none;
		in_addr = '0;
		in_wdata = '0;
		for (int i = 0; i < 64; i++) begin
			mem_bytes[i] = 8'(i * 37 + 90);
			ref_bytes[i] = mem_bytes[i];
		end
		count = load_vectors();
		if (count < 0) begin
			$display("Could not open tests/mem_vectors.txt for reading");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			// a split store with full wait states needs about 30 cycles
			cycle_limit = 40 * count + 10;
			repeat (3)
				@(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			@(posedge clock);
			check_value("idle in_ready", 1, in_ready);
			check_value("idle done", 0, done);
			check_value("idle bus valids", 0, {arvalid, rready, awvalid, wvalid, bready});
			for (int n = 0; n < count; n++)
				run_vector(n);
			repeat (2)
				@(posedge clock);
			check_value("done count", accepts, done_count);
			assert_fails = DUT.u_properties.failures;
			$display("%0d vectors, %0d checks, %0d errors, %0d assertion failures",
				count, checks, errors, assert_fails);
			if (errors == 0 && assert_fails == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/mem_vectors.txt */
# op addr wdata expect, all hex; op 1 lw 2 lh 3 lhu 4 lb 5 lbu 6 sw 7 sh 8 sb
# expect is the load result, stores carry 0
6 00000000 11223344 00000000
7 00000004 0000a5b6 00000000
8 00000006 000000c7 00000000
8 00000007 00000080 00000000
1 00000000 00000000 11223344
3 00000004 00000000 0000a5b6
5 00000006 00000000 000000c7
2 00000004 00000000 ffffa5b6
4 00000007 00000000 ffffff80
5 00000007 00000000 00000080
1 00000004 00000000 80c7a5b6
6 00000009 deadbeef 00000000
1 00000009 00000000 deadbeef
6 00000012 cafef00d 00000000
1 00000012 00000000 cafef00d
6 00000017 89abcdef 00000000
1 00000017 00000000 89abcdef
7 0000000b 00008765 00000000
2 0000000b 00000000 ffff8765
3 0000000b 00000000 00008765
1 00000009 00000000 8765beef
2 00000013 00000000 fffffef0
4 00000015 00000000 ffffffca
5 0000001a 00000000 00000089

/* sim.f */
+incdir+include
rtl/mem_pkg.sv
rtl/mem_issue.sv
rtl/access_split.sv
rtl/axi_read_fsm.sv
rtl/axi_write_fsm.sv
rtl/load_align.sv
rtl/mem_stage.sv
tests/mem_stage_properties.sv
tests/mem_stage_tb.sv
